// File: sim.f
logic/ffu_reg_pkg.sv
logic/ffu_ctl_pkg.sv
logic/ffu_frf_align.sv
logic/ffu_operand_regs.sv
logic/ffu_fsr_file.sv
logic/ffu_gsr_file.sv
logic/ffu_dp.sv
sim/ffu_dp_chk.sv
sim/ffu_dp_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module ffu_dp_tb -f sim.f -o ffu_dp_sim

out=$(./obj_dir/ffu_dp_sim 2>&1) || true
echo "$out"

if grep -q "TEST RESULT: PASS" <<< "$out"; then
   exit 0
fi
exit 1

// File: sim/ffu_dp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ffu_dp_tb;

   import ffu_reg_pkg::*;
   import ffu_ctl_pkg::*;

   localparam int NT = 4;

   logic              rclk;
   logic              rst;
   dword_t            frf_rd_data;
   dword_t            cpx_fpu_data;
   dword_t            lsu_ld_data;
   dp_sel_t           sel;
   fsr_upd_e [NT-1:0] fsr_upd;
   fpu_result_t       fpu_res;
   logic [1:0]        fp_thr;
   logic [NT-1:0]     gsr_wr;
   gsr_t              gsr_wr_data;
   logic [1:0]        thr_e;
   dword_t            frf_wr_data;
   dword_t            lsu_st_data;
   dword_t            vis_rs1_data;
   dword_t            vis_rs2_data;
   logic [1:0]        rs2_sign;
   fsr_t              cur_fsr;
   logic [7:0]        ld_fcc;
   gsr_t              gsr_e;

   // reference model state
   dword_t ld_m;
   dword_t fpu_m;
   dword_t rs1_m;
   dword_t rs2_m;
   dword_t wb_m;
   fsr_t   fsr_m [NT];
   gsr_t   gsr_m [NT];
   logic   chk_en;
   int     errors;

   ffu_dp #(.NUM_THREADS(NT)) dut_i (
      .rclk         (rclk),
      .rst          (rst),
      .frf_rd_data  (frf_rd_data),
      .cpx_fpu_data (cpx_fpu_data),
      .lsu_ld_data  (lsu_ld_data),
      .sel          (sel),
      .fsr_upd      (fsr_upd),
      .fpu_res      (fpu_res),
      .fp_thr       (fp_thr),
      .gsr_wr       (gsr_wr),
      .gsr_wr_data  (gsr_wr_data),
      .thr_e        (thr_e),
      .frf_wr_data  (frf_wr_data),
      .lsu_st_data  (lsu_st_data),
      .vis_rs1_data (vis_rs1_data),
      .vis_rs2_data (vis_rs2_data),
      .rs2_sign     (rs2_sign),
      .cur_fsr      (cur_fsr),
      .ld_fcc       (ld_fcc),
      .gsr_e        (gsr_e)
   );

   always #5 rclk = ~rclk;

   ////////////////////////////////////////
   // reference functions
   ////////////////////////////////////////
   function automatic dword_t align_ref(dword_t d, frf_align_e a);
      dword_t r;
      case (a)
         ALIGN_RIGHT: r = {32'h0, d[63:32]};
         ALIGN_LEFT:  r = {d[31:0], 32'h0};
         default:     r = d;
      endcase
      return r;
   endfunction

   function automatic dword_t zeroed_ref(dword_t d, dp_sel_t s);
      dword_t r;
      r = align_ref(d, s.align);
      if (s.zero_low32) begin
         r[31:0] = 32'h0;
      end
      return r;
   endfunction

   function automatic dword_t rs2_ref(dword_t d, dp_sel_t s);
      dword_t r;
      r = zeroed_ref(d, s);
      r[63] = s.sign[1];  // FABS / FNEG
      r[31] = s.sign[0];
      return r;
   endfunction

   function automatic dword_t fill_ref(dword_t ld, dword_t fpu, fill_src_e f);
      dword_t r;
      case (f)
         FILL_LSU:      r = ld;
         FILL_LSU_FLIP: r = {ld[31:0], 32'h0};
         FILL_FPU:      r = fpu;
         default:       r = {32'h0, fpu[63:32]};
      endcase
      return r;
   endfunction

   function automatic fsr_t fsr_next_ref(fsr_t old, fsr_upd_e u, dword_t ld, fpu_result_t res);
      fsr_t n;
      n = old;
      if (u == FSR_LD) begin
         n.fcc_hi = res.fcc[7:2];
         n.rnd    = ld[31:30];
         n.tem    = ld[27:23];
         n.fcc0   = ld[11:10];
         n.aexc   = ld[9:5];
         n.cexc   = ld[4:0];
      end else if (u == FSR_FPU) begin
         n.fcc_hi = res.fcc[7:2];
         n.ftt    = res.ftt;
         n.fcc0   = res.fcc[1:0];
         n.aexc   = res.exc[9:5];
         n.cexc   = res.exc[4:0];
      end
      return n;
   endfunction

   function automatic dword_t fsr_image_ref(fsr_t f);
      dword_t r;
      r = '0;
      r[37:32] = f.fcc_hi;
      r[31:30] = f.rnd;
      r[27:23] = f.tem;
      r[16:14] = f.ftt;
      r[11:10] = f.fcc0;
      r[9:5]   = f.aexc;
      r[4:0]   = f.cexc;
      return r;
   endfunction

   function automatic dword_t store_ref(dp_sel_t s, dword_t frf, dword_t rs1, dword_t rs2,
                                        fsr_t f);
      dword_t r;
      case (s.st)
         ST_RS2:  r = rs2;
         ST_RS1:  r = rs1;
         ST_FRF:  r = align_ref(frf, s.align);  // no low-word zeroing here
         default: r = fsr_image_ref(f);
      endcase
      return r;
   endfunction

   function automatic dp_sel_t idle_sel();
      dp_sel_t s;
      s = '0;
      s.rs2 = RS2_KEEP;
      s.st  = st_sel_e'(2'($urandom));
      return s;
   endfunction

   ////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////
   task automatic abort_run();
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopping at first mismatch");
   endtask

   task automatic check_dword(string what, dword_t got, dword_t exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL @%0t: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_fsr(fsr_t got, fsr_t exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL @%0t: cur_fsr is %h, expected %h", $time, got, exp);
         abort_run();
      end
   endtask

   task automatic check_gsr(gsr_t got, gsr_t exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL @%0t: gsr_e is %h, expected %h", $time, got, exp);
         abort_run();
      end
   endtask

   task automatic check_sign(logic [1:0] got, logic [1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL @%0t: rs2_sign is %b, expected %b", $time, got, exp);
         abort_run();
      end
   endtask

   task automatic check_fcc(logic [7:0] got, logic [7:0] exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL @%0t: ld_fcc is %h, expected %h", $time, got, exp);
         abort_run();
      end
   endtask

   ////////////////////////////////////////
   // cycle model, sees the same inputs as the DUT
   ////////////////////////////////////////
   always @(posedge rclk) begin
      ld_m  <= lsu_ld_data;
      fpu_m <= cpx_fpu_data;
      wb_m  <= rs2_m;
      case (sel.rs2)
         RS2_FRF:  rs2_m <= rs2_ref(frf_rd_data, sel);
         RS2_FILL: rs2_m <= fill_ref(ld_m, fpu_m, sel.fill);
         default:  ;
      endcase
      if (sel.new_rs1) begin
         rs1_m <= zeroed_ref(frf_rd_data, sel);
      end
      for (int t = 0; t < NT; t++) begin
         if (rst) begin
            fsr_m[t] <= '0;
            gsr_m[t] <= '0;
         end else begin
            fsr_m[t] <= fsr_next_ref(fsr_m[t], fsr_upd[t], ld_m, fpu_res);
            if (gsr_wr[t]) begin
               gsr_m[t] <= gsr_wr_data;
            end
         end
      end
   end

   // outputs are settled by the falling edge
   always @(negedge rclk) begin
      dword_t al;
      if (chk_en) begin
         al = zeroed_ref(frf_rd_data, sel);
         check_dword("vis_rs2_data", vis_rs2_data, rs2_m);
         check_dword("frf_wr_data", frf_wr_data, wb_m);
         check_dword("vis_rs1_data", vis_rs1_data, rs1_m);
         check_dword("lsu_st_data", lsu_st_data,
                     store_ref(sel, frf_rd_data, rs1_m, rs2_m, fsr_m[fp_thr]));
         check_sign(rs2_sign, {al[63], al[31]});
         check_fcc(ld_fcc, {ld_m[37:32], ld_m[11:10]});
         check_fsr(cur_fsr, fsr_m[fp_thr]);
         check_gsr(gsr_e, gsr_m[thr_e]);
      end
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////
   initial begin
      dp_sel_t           s;
      fsr_upd_e [NT-1:0] upd;
      logic [NT-1:0]     wr;
      int                thr;
      void'($urandom(32'h08c2_fc86));
      errors       = 0;
      chk_en       = 1'b0;
      rclk         = 1'b0;
      rst          = 1'b1;
      frf_rd_data  = '0;
      cpx_fpu_data = '0;
      lsu_ld_data  = '0;
      fpu_res      = '0;
      fp_thr       = '0;
      gsr_wr       = '0;
      gsr_wr_data  = '0;
      thr_e        = '0;
      for (int t = 0; t < NT; t++) begin
         fsr_upd[t] = FSR_KEEP;
      end
      s         = idle_sel();
      s.rs2     = RS2_FRF;  // data regs have no reset, load them with zero
      s.new_rs1 = 1'b1;
      sel       = s;

      repeat (2) @(posedge rclk);
      rst    <= 1'b0;
      chk_en <= 1'b1;
      sel    <= idle_sel();

      // every thread reads zero after reset
      for (int i = 0; i < NT; i++) begin
         @(posedge rclk);
         fp_thr <= 2'(i);
         thr_e  <= 2'(i);
      end

      // FRF reads into RS2 and RS1
      repeat (48) begin
         @(posedge rclk);
         s            = idle_sel();
         s.align      = frf_align_e'(2'($urandom_range(0, 2)));
         s.zero_low32 = 1'($urandom);
         s.sign       = 2'($urandom);
         s.rs2        = RS2_FRF;
         s.new_rs1    = 1'($urandom);
         if ($urandom_range(0, 1) == 0) begin
            s.st = ST_FRF;
         end
         frf_rd_data <= {$urandom, $urandom};
         sel         <= s;
      end

      // back to back fills, every fifth cycle holds
      for (int i = 0; i < 40; i++) begin
         @(posedge rclk);
         s      = idle_sel();
         s.fill = fill_src_e'(2'(i));
         s.rs2  = (i % 5 == 4) ? RS2_KEEP : RS2_FILL;
         lsu_ld_data  <= {$urandom, $urandom};
         cpx_fpu_data <= {$urandom, $urandom};
         sel          <= s;
      end

      // FSR updates on one thread at a time
      repeat (48) begin
         @(posedge rclk);
         thr = $urandom_range(0, NT - 1);
         for (int t = 0; t < NT; t++) begin
            upd[t] = FSR_KEEP;
         end
         upd[thr] = fsr_upd_e'(2'($urandom_range(0, 2)));
         s        = idle_sel();
         s.st     = ST_FSR;
         fsr_upd     <= upd;
         fpu_res     <= 21'($urandom);
         lsu_ld_data <= {$urandom, $urandom};
         fp_thr      <= 2'($urandom);
         sel         <= s;
      end
      @(posedge rclk);
      for (int t = 0; t < NT; t++) begin
         upd[t] = FSR_KEEP;
      end
      fsr_upd <= upd;

      // GSR writes, read back on random threads
      repeat (40) begin
         @(posedge rclk);
         thr     = $urandom_range(0, NT - 1);
         wr      = '0;
         wr[thr] = ($urandom_range(0, 3) != 0);
         gsr_wr      <= wr;
         gsr_wr_data <= 37'({$urandom, $urandom});
         thr_e       <= 2'($urandom);
         sel         <= idle_sel();
      end
      @(posedge rclk);
      gsr_wr <= '0;
      for (int i = 0; i < NT; i++) begin
         @(posedge rclk);
         thr_e <= 2'(i);
      end

      repeat (3) @(posedge rclk);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/ffu_dp_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ffu_dp_chk (
   input logic                 rclk,
   input logic                 rst,
   input ffu_ctl_pkg::dp_sel_t sel,
   input ffu_reg_pkg::dword_t  vis_rs1_data,
   input ffu_reg_pkg::dword_t  vis_rs2_data,
   input ffu_reg_pkg::dword_t  frf_wr_data,
   input ffu_reg_pkg::fsr_t    cur_fsr,
   input ffu_reg_pkg::gsr_t    gsr_e
);

   // write-back trails RS2 by one edge
   wb_follows_rs2: assert property (@(posedge rclk)
      !rst && !$past(rst) |-> frf_wr_data == $past(vis_rs2_data))
      else $error("frf_wr_data is not last cycle's vis_rs2_data");

   status_cleared: assert property (@(posedge rclk)
      rst |=> cur_fsr == '0 && gsr_e == '0)
      else $error("FSR or GSR not cleared by reset");

   rs1_holds: assert property (@(posedge rclk)
      !rst && !sel.new_rs1 |=> $stable(vis_rs1_data))
      else $error("vis_rs1_data changed without new_rs1");

endmodule

bind ffu_dp ffu_dp_chk chk_i (
   .rclk         (rclk),
   .rst          (rst),
   .sel          (sel),
   .vis_rs1_data (vis_rs1_data),
   .vis_rs2_data (vis_rs2_data),
   .frf_wr_data  (frf_wr_data),
   .cur_fsr      (cur_fsr),
   .gsr_e        (gsr_e)
);

`default_nettype wire

// File: logic/ffu_dp.sv
`timescale 1ns/1ps
`default_nettype none

module ffu_dp #(
   parameter  int NUM_THREADS = 4,
   localparam int THR_W       = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1
) (
   input  logic                                     rclk,
   input  logic                                     rst,
   input  ffu_reg_pkg::dword_t                      frf_rd_data,
   input  ffu_reg_pkg::dword_t                      cpx_fpu_data,
   input  ffu_reg_pkg::dword_t                      lsu_ld_data,
   input  ffu_ctl_pkg::dp_sel_t                     sel,
   input  ffu_ctl_pkg::fsr_upd_e [NUM_THREADS-1:0] fsr_upd,
   input  ffu_reg_pkg::fpu_result_t                 fpu_res,
   input  logic [THR_W-1:0]                         fp_thr,
   input  logic [NUM_THREADS-1:0]                   gsr_wr,
   input  ffu_reg_pkg::gsr_t                        gsr_wr_data,
   input  logic [THR_W-1:0]                         thr_e,
   output ffu_reg_pkg::dword_t                      frf_wr_data,
   output ffu_reg_pkg::dword_t                      lsu_st_data,
   output ffu_reg_pkg::dword_t                      vis_rs1_data,
   output ffu_reg_pkg::dword_t                      vis_rs2_data,
   output logic [1:0]                               rs2_sign,
   output ffu_reg_pkg::fsr_t                        cur_fsr,
   output logic [7:0]                               ld_fcc,
   output ffu_reg_pkg::gsr_t                        gsr_e
);

   import ffu_reg_pkg::*;
   import ffu_ctl_pkg::*;

   if (NUM_THREADS < 1 || NUM_THREADS > MAX_THREADS) begin : g_thr_chk
      $error("NUM_THREADS out of range");
   end

   dword_t aligned;
   dword_t frf_data;
   dword_t ld_q;
   dword_t fsr_image;

   ffu_frf_align align_i (
      .frf_rd_data (frf_rd_data),
      .align       (sel.align),
      .zero_low32  (sel.zero_low32),
      .aligned     (aligned),
      .frf_data    (frf_data),
      .rs2_sign    (rs2_sign)
   );

   ffu_operand_regs opnd_i (
      .rclk         (rclk),
      .sel          (sel),
      .aligned      (aligned),
      .cpx_fpu_data (cpx_fpu_data),
      .lsu_ld_data  (lsu_ld_data),
      .ld_q         (ld_q),
      .rs1_data     (vis_rs1_data),
      .rs2_data     (vis_rs2_data),
      .frf_wr_data  (frf_wr_data)
   );

   ffu_fsr_file #(.NUM_THREADS(NUM_THREADS)) fsr_i (
      .rclk    (rclk),
      .rst     (rst),
      .fsr_upd (fsr_upd),
      .ld_q    (ld_q),
      .fpu_res (fpu_res),
      .fp_thr  (fp_thr),
      .cur_fsr (cur_fsr)
   );

   ffu_gsr_file #(.NUM_THREADS(NUM_THREADS)) gsr_i (
      .rclk        (rclk),
      .rst         (rst),
      .gsr_wr      (gsr_wr),
      .gsr_wr_data (gsr_wr_data),
      .thr_e       (thr_e),
      .gsr_e       (gsr_e)
   );

   // fcc out of a ldfsr for the control block
   assign ld_fcc = {ld_q[FSR_FCC_HI_LSB +: 6], ld_q[FSR_FCC0_LSB +: 2]};

   ////////////////////////////////////////
   // store data to LSU
   ////////////////////////////////////////
   always_comb begin
      fsr_image = '0;  // reserved, ver, qne all zero
      fsr_image[FSR_FCC_HI_LSB +: 6] = cur_fsr.fcc_hi;
      fsr_image[FSR_RND_LSB +: 2]    = cur_fsr.rnd;
      fsr_image[FSR_TEM_LSB +: 5]    = cur_fsr.tem;
      fsr_image[FSR_FTT_LSB +: 3]    = cur_fsr.ftt;
      fsr_image[FSR_FCC0_LSB +: 2]   = cur_fsr.fcc0;
      fsr_image[9:0]                 = {cur_fsr.aexc, cur_fsr.cexc};
   end

   always_comb begin
      case (sel.st)
         ST_RS2:  lsu_st_data = vis_rs2_data;
         ST_RS1:  lsu_st_data = vis_rs1_data;
         ST_FRF:  lsu_st_data = frf_data;  // direct store from FRF
         default: lsu_st_data = fsr_image;
      endcase
   end

endmodule

`default_nettype wire

// File: logic/ffu_gsr_file.sv
`timescale 1ns/1ps
`default_nettype none

module ffu_gsr_file #(
   parameter  int NUM_THREADS = 4,
   localparam int THR_W       = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1
) (
   input  logic                   rclk,
   input  logic                   rst,
   input  logic [NUM_THREADS-1:0] gsr_wr,
   input  ffu_reg_pkg::gsr_t      gsr_wr_data,
   input  logic [THR_W-1:0]       thr_e,
   output ffu_reg_pkg::gsr_t      gsr_e
);

   import ffu_reg_pkg::*;

   gsr_t gsr_q [NUM_THREADS];

   // wr/rd of the GSR from the w2 stage
   always_ff @(posedge rclk) begin
      for (int t = 0; t < NUM_THREADS; t++) begin
         if (rst) begin
            gsr_q[t] <= '0;
         end else if (gsr_wr[t]) begin
            gsr_q[t] <= gsr_wr_data;
         end
      end
   end

   assign gsr_e = (int'(thr_e) < NUM_THREADS) ? gsr_q[thr_e] : '0;  // execute-stage read

endmodule

`default_nettype wire

// File: logic/ffu_fsr_file.sv
`timescale 1ns/1ps
`default_nettype none

module ffu_fsr_file #(
   parameter  int NUM_THREADS = 4,
   localparam int THR_W       = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1
) (
   input  logic                                     rclk,
   input  logic                                     rst,
   input  ffu_ctl_pkg::fsr_upd_e [NUM_THREADS-1:0] fsr_upd,
   input  ffu_reg_pkg::dword_t                      ld_q,
   input  ffu_reg_pkg::fpu_result_t                 fpu_res,
   input  logic [THR_W-1:0]                         fp_thr,
   output ffu_reg_pkg::fsr_t                        cur_fsr
);

   import ffu_reg_pkg::*;
   import ffu_ctl_pkg::*;

   fsr_t fsr_q   [NUM_THREADS];
   fsr_t ld_fsr  [NUM_THREADS];
   fsr_t fpu_fsr [NUM_THREADS];
   fsr_t fsr_nxt [NUM_THREADS];

   ////////////////////////////////////////
   // next-state per thread
   ////////////////////////////////////////
   always_comb begin
      for (int t = 0; t < NUM_THREADS; t++) begin
         // ldfsr / ldxfsr, upper fcc comes with the FPU status
         ld_fsr[t].fcc_hi = fpu_res.fcc[7:2];
         ld_fsr[t].rnd    = ld_q[FSR_RND_LSB +: 2];
         ld_fsr[t].tem    = ld_q[FSR_TEM_LSB +: 5];
         ld_fsr[t].ftt    = fsr_q[t].ftt;  // ftt not loadable
         ld_fsr[t].fcc0   = ld_q[FSR_FCC0_LSB +: 2];
         {ld_fsr[t].aexc, ld_fsr[t].cexc} = ld_q[9:0];

         // FPU op leaves the mode fields alone
         fpu_fsr[t].fcc_hi = fpu_res.fcc[7:2];
         fpu_fsr[t].rnd    = fsr_q[t].rnd;
         fpu_fsr[t].tem    = fsr_q[t].tem;
         fpu_fsr[t].ftt    = fpu_res.ftt;
         fpu_fsr[t].fcc0   = fpu_res.fcc[1:0];
         {fpu_fsr[t].aexc, fpu_fsr[t].cexc} = fpu_res.exc;

         case (fsr_upd[t])
            FSR_LD:  fsr_nxt[t] = ld_fsr[t];
            FSR_FPU: fsr_nxt[t] = fpu_fsr[t];
            default: fsr_nxt[t] = fsr_q[t];
         endcase
      end
   end

   always_ff @(posedge rclk) begin
      for (int t = 0; t < NUM_THREADS; t++) begin
         if (rst) begin
            fsr_q[t] <= '0;
         end else begin
            fsr_q[t] <= fsr_nxt[t];
         end
      end
   end

   // thread codes past NUM_THREADS read as zero
   assign cur_fsr = (int'(fp_thr) < NUM_THREADS) ? fsr_q[fp_thr] : '0;

endmodule

`default_nettype wire

// File: logic/ffu_operand_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ffu_operand_regs (
   input  logic                 rclk,
   input  ffu_ctl_pkg::dp_sel_t sel,
   input  ffu_reg_pkg::dword_t  aligned,
   input  ffu_reg_pkg::dword_t  cpx_fpu_data,
   input  ffu_reg_pkg::dword_t  lsu_ld_data,
   output ffu_reg_pkg::dword_t  ld_q,
   output ffu_reg_pkg::dword_t  rs1_data,
   output ffu_reg_pkg::dword_t  rs2_data,
   output ffu_reg_pkg::dword_t  frf_wr_data
);

   import ffu_reg_pkg::*;
   import ffu_ctl_pkg::*;

   dword_t fpu_q;
   dword_t ld_d1;
   dword_t fill_data;
   dword_t rs2_changed;
   dword_t rs2_next;
   dword_t rs2_q;
   dword_t rs1_q;
   dword_t wb_q;

   ////////////////////////////////////////
   // input flops
   ////////////////////////////////////////
   // load data is flopped here, its valid is flopped in the LSU
   always_ff @(posedge rclk) begin
      fpu_q <= cpx_fpu_data;
      ld_d1 <= lsu_ld_data;
   end

   assign ld_q = ld_d1;

   always_comb begin
      case (sel.fill)
         FILL_LSU:      fill_data = ld_d1;
         FILL_LSU_FLIP: fill_data = {ld_d1[31:0], 32'b0};
         FILL_FPU:      fill_data = fpu_q;
         default:       fill_data = {32'b0, fpu_q[63:32]};  // FPU single result
      endcase
   end

   ////////////////////////////////////////
   // RS2 / RD
   ////////////////////////////////////////
   // replaced signs give FABS and FNEG
   assign rs2_changed = {sel.sign[1], aligned[62:32], sel.sign[0], aligned[30:0]};

   always_comb begin
      case (sel.rs2)
         RS2_FRF:  rs2_next = rs2_changed;
         RS2_FILL: rs2_next = fill_data;
         default:  rs2_next = rs2_q;
      endcase
   end

   always_ff @(posedge rclk) begin
      rs2_q <= rs2_next;
      wb_q  <= rs2_q;  // block loads are pipelined behind RS2
      if (sel.new_rs1) begin
         rs1_q <= aligned;
      end
   end

   assign rs2_data    = rs2_q;
   assign rs1_data    = rs1_q;
   assign frf_wr_data = wb_q;

endmodule

`default_nettype wire

// File: logic/ffu_frf_align.sv
`timescale 1ns/1ps
`default_nettype none

module ffu_frf_align (
   input  ffu_reg_pkg::dword_t     frf_rd_data,
   input  ffu_ctl_pkg::frf_align_e align,
   input  logic                    zero_low32,
   output ffu_reg_pkg::dword_t     aligned,
   output ffu_reg_pkg::dword_t     frf_data,
   output logic [1:0]              rs2_sign
);

   import ffu_reg_pkg::*;
   import ffu_ctl_pkg::*;

   dword_t shifted;

   // singles can sit in either half of a 64-bit read
   always_comb begin
      case (align)
         ALIGN_RIGHT: shifted = {32'b0, frf_rd_data[63:32]};
         ALIGN_LEFT:  shifted = {frf_rd_data[31:0], 32'b0};
         default:     shifted = frf_rd_data;  // doubles untouched
      endcase
   end

   assign frf_data = shifted;  // store path sees it unzeroed

   assign aligned[63:32] = shifted[63:32];
   assign aligned[31:0]  = zero_low32 ? 32'b0 : shifted[31:0];

   // sign bits taken after low-word zeroing
   assign rs2_sign = {aligned[63], aligned[31]};

endmodule

`default_nettype wire

// File: logic/ffu_ctl_pkg.sv
`default_nettype none

package ffu_ctl_pkg;

   // FRF read alignment for singles
   typedef enum logic [1:0] {
      ALIGN_NONE,
      ALIGN_RIGHT,  // upper word down, upper zero
      ALIGN_LEFT    // lower word up, lower zero
   } frf_align_e;

   // load or FPU data into RS2/RD
   typedef enum logic [1:0] {
      FILL_LSU,
      FILL_LSU_FLIP,  // lower word up
      FILL_FPU,
      FILL_FPU_FLIP   // upper word down
   } fill_src_e;

   typedef enum logic [1:0] {
      RS2_FRF,   // FRF with sign replaced
      RS2_FILL,
      RS2_KEEP
   } rs2_src_e;

   // LSU store data source
   typedef enum logic [1:0] {
      ST_RS2,
      ST_RS1,
      ST_FRF,
      ST_FSR
   } st_sel_e;

   // per-thread FSR update
   typedef enum logic [1:0] {
      FSR_KEEP,
      FSR_LD,
      FSR_FPU
   } fsr_upd_e;

   ////////////////////////////////////////
   // datapath controls for one cycle
   ////////////////////////////////////////
   typedef struct packed {
      frf_align_e align;
      logic       zero_low32;
      logic [1:0] sign;     // new sign for upper word, then lower word
      fill_src_e  fill;
      rs2_src_e   rs2;
      logic       new_rs1;
      st_sel_e    st;
   } dp_sel_t;

endpackage

`default_nettype wire

// File: logic/ffu_reg_pkg.sv
`default_nettype none

package ffu_reg_pkg;

   ////////////////////////////////////////
   // architectural register layouts
   ////////////////////////////////////////

   typedef logic [63:0] dword_t;

   // only the live FSR bits are stored, the rest read as zero
   typedef struct packed {
      logic [5:0] fcc_hi;  // fcc3, fcc2, fcc1
      logic [1:0] rnd;
      logic [4:0] tem;
      logic [2:0] ftt;
      logic [1:0] fcc0;
      logic [4:0] aexc;
      logic [4:0] cexc;
   } fsr_t;

   // align and rnd fields of the GSR live in the control block
   typedef struct packed {
      logic [31:0] mask;
      logic [4:0]  scale;
   } gsr_t;

   // status returned with an FPU result
   typedef struct packed {
      logic [7:0] fcc;  // fcc3..fcc0
      logic [2:0] ftt;
      logic [9:0] exc;  // aexc then cexc
   } fpu_result_t;

   ////////////////////////////////////////
   // 64-bit FSR image, for ldxfsr and stxfsr
   ////////////////////////////////////////

   localparam int FSR_FCC_HI_LSB = 32;
   localparam int FSR_RND_LSB    = 30;
   localparam int FSR_TEM_LSB    = 23;
   localparam int FSR_FTT_LSB    = 14;
   localparam int FSR_FCC0_LSB   = 10;
   // aexc and cexc sit in bits 9..0

   localparam int MAX_THREADS = 4;

endpackage

`default_nettype wire
